// File: sim.f
src/mcuPkg.sv
src/devBoard.sv
src/uart.sv
src/intController.sv
src/mcuResources.sv
src/mcu.sv
tests/tbMcu.sv

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tbMcu -Mdir obj_dir -o simMcu -f sim.f; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/simMcu)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation returned status $status"
	exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

// File: tests/tbMcu.sv
module tbMcu import mcuPkg::*; ();

	typedef enum logic [3:0] {
		opWrite, opWriteRand, opRead, opReadRam, opLed, opLines,
		opPin, opSend, opWait, opTxByte, opNoTx
	} opType;

	typedef struct packed {
		opType                op;
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] data;
		logic [1:0]           strb; // Bit 0 low lane, bit 1 high lane
		logic [dataWidth-1:0] expVal;
	} stepType;

	localparam int clkPeriod = 4;
	localparam int bitTime = clocksPerBit * clkPeriod;
	localparam logic [3:0] dipValue = 4'hB;

	logic                 CLK = 1'b0;
	logic                 arstN;
	logic [addrWidth-1:0] addr;
	logic [dataWidth-1:0] dout;
	logic                 rdN;
	logic                 wr0N;
	logic                 wr1N;
	logic [6:0]           intPins;
	logic                 rxd;
	logic [3:0]           dipSw;
	logic [dataWidth-1:0] din;
	logic                 int0;
	logic                 int1;
	logic                 txd;
	logic [7:0]           led;

	stepType              steps[$];
	logic [dataWidth-1:0] ramModel [ramWords];
	logic [7:0]           txBytes[$]; // Bytes decoded from txd
	logic [7:0]           frameByte;
	integer               seed;
	int                   cycleBudget = 0;

	mcu u_mcu (
		.CLK(CLK),
		.arstN(arstN),
		.addr(addr),
		.dout(dout),
		.rdN(rdN),
		.wr0N(wr0N),
		.wr1N(wr1N),
		.intPins(intPins),
		.rxd(rxd),
		.dipSw(dipSw),
		.din(din),
		.int0(int0),
		.int1(int1),
		.txd(txd),
		.led(led)
	);

	always #(clkPeriod / 2) CLK = ~CLK;

	task automatic abortRun();
		$display("TB FAILED");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic checkWord(string name, logic [dataWidth-1:0] got,
			logic [dataWidth-1:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkByte(string name, logic [7:0] got, logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
			abortRun();
		end
	endtask

	// Every bus task starts and ends one unit after a rising edge
	task automatic nextCycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic busWrite(logic [addrWidth-1:0] a, logic [dataWidth-1:0] d, logic [1:0] s);
		addr = a;
		dout = d;
		wr0N = !s[0];
		wr1N = !s[1];
		nextCycle();
		wr0N = 1'b1;
		wr1N = 1'b1;
	endtask

	task automatic busRead(input logic [addrWidth-1:0] a, output logic [dataWidth-1:0] d);
		addr = a;
		rdN  = 1'b0;
		#2;
		d = din; // Sampled mid-cycle, before the edge that takes the read
		nextCycle();
		rdN = 1'b1;
	endtask

	// 8N1 frame, LSB first
	task automatic sendSerial(logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rxd = frame[i];
			repeat (clocksPerBit) nextCycle();
		end
	endtask

	task automatic pulsePin(int p);
		intPins[p] = 1'b1;
		repeat (2) nextCycle();
		intPins[p] = 1'b0;
		repeat (6) nextCycle();
	endtask

	function automatic void addStep(opType op, logic [addrWidth-1:0] a,
			logic [dataWidth-1:0] d, logic [1:0] s, logic [dataWidth-1:0] e);
		steps.push_back(stepType'{op, a, d, s, e});
	endfunction

	function automatic void addRamSteps(logic [addrWidth-1:0] a);
		for (int s = 3; s >= 0; s--) begin
			addStep(opWriteRand, a, 16'h0, 2'(s), 16'h0);
			addStep(opReadRam, a, 16'h0, 2'b00, 16'h0);
		end
	endfunction

	function automatic void addPinSteps(int p);
		logic [dataWidth-1:0] pinBit;
		pinBit = 16'(1 << p);
		addStep(opPin, 16'h0, 16'(p), 2'b00, 16'h0);
		addStep(opRead, intPendAddr, 16'h0, 2'b00, pinBit);
		addStep(opLines, 16'h0, 16'h0, 2'b00, 16'h4);
		addStep(opWrite, intMaskAddr, pinBit, 2'b01, 16'h0);
		addStep(opLines, 16'h0, 16'h0, 2'b00, (p < 4) ? 16'h5 : 16'h6);
		addStep(opWrite, intPendAddr, pinBit, 2'b01, 16'h0);
		addStep(opLines, 16'h0, 16'h0, 2'b00, 16'h4);
		addStep(opWrite, intMaskAddr, 16'h0, 2'b01, 16'h0);
	endfunction

	function automatic int stepCycles(stepType s);
		case (s.op)
			opPin: return 8;
			opSend: return 10 * clocksPerBit;
			opWait: return int'(s.data);
			opTxByte: return 12 * clocksPerBit;
			default: return 1;
		endcase
	endfunction

	// opLines expects {txd, int1, int0} in the low bits
	function automatic void buildTable();
		addStep(opLines, 16'h0, 16'h0, 2'b00, 16'h4);
		addStep(opLed, 16'h0, 16'h0, 2'b00, 16'h0);
		addStep(opRead, uartStatusAddr, 16'h0, 2'b00, 16'h0);
		addStep(opRead, intMaskAddr, 16'h0, 2'b00, 16'h0);
		addStep(opRead, intPendAddr, 16'h0, 2'b00, 16'h0);
		addRamSteps(16'h0000);
		addRamSteps(16'h0155);
		addRamSteps(16'h03FF);
		addStep(opRead, 16'h0400, 16'h0, 2'b00, 16'h0);
		addStep(opRead, 16'hE7FF, 16'h0, 2'b00, 16'h0);
		addStep(opWrite, gpioAddr, 16'hA55A, 2'b11, 16'h0);
		addStep(opLed, 16'h0, 16'h0, 2'b00, 16'h005A);
		addStep(opWrite, gpioAddr, 16'hFF00, 2'b10, 16'h0);
		addStep(opLed, 16'h0, 16'h0, 2'b00, 16'h005A);
		addStep(opRead, gpioAddr, 16'h0, 2'b00, {12'h0, dipValue});
		addStep(opWrite, uartDataAddr, 16'h003C, 2'b01, 16'h0);
		addStep(opWrite, uartDataAddr, 16'h0077, 2'b01, 16'h0); // Busy, dropped
		addStep(opRead, uartStatusAddr, 16'h0, 2'b00, 16'h0001);
		addStep(opTxByte, 16'h0, 16'h0, 2'b00, 16'h003C);
		addStep(opRead, uartStatusAddr, 16'h0, 2'b00, 16'h0001);
		addStep(opWait, 16'h0, 16'd8, 2'b00, 16'h0);
		addStep(opRead, uartStatusAddr, 16'h0, 2'b00, 16'h0);
		addStep(opLines, 16'h0, 16'h0, 2'b00, 16'h4);
		addStep(opWait, 16'h0, 16'd90, 2'b00, 16'h0);
		addStep(opNoTx, 16'h0, 16'h0, 2'b00, 16'h0);
		addStep(opWrite, intMaskAddr, 16'h0080, 2'b01, 16'h0);
		addStep(opRead, intMaskAddr, 16'h0, 2'b00, 16'h0080);
		addStep(opSend, 16'h0, 16'h00A7, 2'b00, 16'h0);
		addStep(opRead, uartStatusAddr, 16'h0, 2'b00, 16'h0002);
		addStep(opLines, 16'h0, 16'h0, 2'b00, 16'h6);
		addStep(opRead, uartDataAddr, 16'h0, 2'b00, 16'h00A7);
		addStep(opRead, uartStatusAddr, 16'h0, 2'b00, 16'h0);
		addStep(opRead, intPendAddr, 16'h0, 2'b00, 16'h0080);
		addStep(opWrite, intPendAddr, 16'h0080, 2'b01, 16'h0);
		addStep(opLines, 16'h0, 16'h0, 2'b00, 16'h4);
		addStep(opWrite, intMaskAddr, 16'h0, 2'b01, 16'h0);
		addPinSteps(2);
		addPinSteps(5);
	endfunction

	task automatic applyStep(stepType s);
		logic [dataWidth-1:0] got;
		logic [dataWidth-1:0] word;
		int                   waited;
		waited = 0;
		case (s.op)
			opWrite: busWrite(s.addr, s.data, s.strb);
			opWriteRand: begin
				word = 16'($random(seed));
				busWrite(s.addr, word, s.strb);
				if (s.strb[0]) ramModel[s.addr[ramAddrWidth-1:0]][7:0] = word[7:0];
				if (s.strb[1]) ramModel[s.addr[ramAddrWidth-1:0]][15:8] = word[15:8];
			end
			opRead: begin
				busRead(s.addr, got);
				checkWord($sformatf("din from %h", s.addr), got, s.expVal);
			end
			opReadRam: begin
				busRead(s.addr, got);
				checkWord($sformatf("din from %h", s.addr), got,
					ramModel[s.addr[ramAddrWidth-1:0]]);
			end
			opLed: checkByte("led", led, s.expVal[7:0]);
			opLines: begin
				checkBit("int0", int0, s.expVal[0]);
				checkBit("int1", int1, s.expVal[1]);
				checkBit("txd", txd, s.expVal[2]);
			end
			opPin: pulsePin(int'(s.data[2:0]));
			opSend: sendSerial(s.data[7:0]);
			opWait: repeat (s.data) nextCycle();
			opTxByte: begin
				while (txBytes.size() == 0 && waited < 12 * clocksPerBit) begin
					nextCycle();
					waited++;
				end
				if (txBytes.size() == 0) begin
					$display("No serial frame appeared on txd after the data write");
					abortRun();
				end
				checkByte("txd frame", txBytes.pop_front(), s.expVal[7:0]);
			end
			opNoTx: begin
				if (txBytes.size() != 0) begin
					$display("txd sent a frame for a data write made while busy");
					abortRun();
				end
			end
			default: ;
		endcase
	endtask

	// Samples land between clock edges, half a bit after each boundary
	initial begin
		wait (arstN === 1'b1);
		forever begin
			@(negedge txd);
			#(bitTime / 2 + 2);
			if (txd !== 1'b0) begin
				$display("Start bit on txd did not last half a bit");
				abortRun();
			end
			for (int i = 0; i < 8; i++) begin
				#(bitTime);
				frameByte[i] = txd;
			end
			#(bitTime);
			if (txd !== 1'b1) begin
				$display("Stop bit on txd was missing");
				abortRun();
			end
			txBytes.push_back(frameByte);
		end
	end

	initial begin
		wait (cycleBudget > 0);
		repeat (cycleBudget + 50) @(posedge CLK);
		$display("Timeout after %0d cycles with the test table unfinished", cycleBudget + 50);
		abortRun();
	end

	initial begin
		seed    = 55;
		arstN   = 1'b0;
		addr    = '0;
		dout    = '0;
		rdN     = 1'b1;
		wr0N    = 1'b1;
		wr1N    = 1'b1;
		intPins = '0;
		rxd     = 1'b1;
		dipSw   = dipValue;
		buildTable();
		foreach (steps[i]) cycleBudget += stepCycles(steps[i]);
		repeat (3) @(posedge CLK);
		#1;
		arstN = 1'b1;
		repeat (3) nextCycle(); // Internal reset releases two edges later
		foreach (steps[i]) applyStep(steps[i]);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: src/mcu.sv
module mcu import mcuPkg::*; (
	input  logic                 CLK,
	input  logic                 arstN,
	input  logic [addrWidth-1:0] addr,
	input  logic [dataWidth-1:0] dout,
	input  logic                 rdN,
	input  logic                 wr0N,
	input  logic                 wr1N,
	input  logic [6:0]           intPins,
	input  logic                 rxd,
	input  logic [3:0]           dipSw,
	output logic [dataWidth-1:0] din,
	output logic                 int0,
	output logic                 int1,
	output logic                 txd,
	output logic [7:0]           led
);

	logic               rstN;
	logic [6:0]         intEdge;
	logic               rxdSync;
	logic               uartWr;
	logic               uartRd;
	logic               maskWr;
	logic               pendClrWr;
	logic [7:0]         wrData;
	logic [7:0]         rxData;
	logic               txBusy;
	logic               rxValid;
	logic [numInts-1:0] intMask;
	logic [numInts-1:0] intPending;

	devBoard boardInst (
		.CLK(CLK),
		.arstN(arstN),
		.intPins(intPins),
		.rxd(rxd),
		.rstN(rstN),
		.intEdge(intEdge),
		.rxdSync(rxdSync)
	);

	// CPU bus lands here
	mcuResources mcuResourcesInst (
		.CLK(CLK),
		.rstN(rstN),
		.addr(addr),
		.dout(dout),
		.rdN(rdN),
		.wr0N(wr0N),
		.wr1N(wr1N),
		.dipSw(dipSw),
		.rxData(rxData),
		.txBusy(txBusy),
		.rxValid(rxValid),
		.intMask(intMask),
		.intPending(intPending),
		.din(din),
		.led(led),
		.uartWr(uartWr),
		.uartRd(uartRd),
		.maskWr(maskWr),
		.pendClrWr(pendClrWr),
		.wrData(wrData)
	);

	uart uartInst (
		.CLK(CLK),
		.rstN(rstN),
		.rxdSync(rxdSync),
		.wr(uartWr),
		.rd(uartRd),
		.wrData(wrData),
		.txd(txd),
		.txBusy(txBusy),
		.rxData(rxData),
		.rxValid(rxValid)
	);

	intController intCtrlInst (
		.CLK(CLK),
		.rstN(rstN),
		.intEdge(intEdge),
		.rxValid(rxValid),
		.maskWr(maskWr),
		.pendClrWr(pendClrWr),
		.wrData(wrData),
		.intMask(intMask),
		.intPending(intPending),
		.int0(int0),
		.int1(int1)
	);

endmodule

// File: src/mcuResources.sv
module mcuResources import mcuPkg::*; (
	input  logic                 CLK,
	input  logic                 rstN,
	input  logic [addrWidth-1:0] addr,
	input  logic [dataWidth-1:0] dout,
	input  logic                 rdN,
	input  logic                 wr0N,
	input  logic                 wr1N,
	input  logic [3:0]           dipSw,
	input  logic [7:0]           rxData,
	input  logic                 txBusy,
	input  logic                 rxValid,
	input  logic [numInts-1:0]   intMask,
	input  logic [numInts-1:0]   intPending,
	output logic [dataWidth-1:0] din,
	output logic [7:0]           led,
	output logic                 uartWr,
	output logic                 uartRd,
	output logic                 maskWr,
	output logic                 pendClrWr,
	output logic [7:0]           wrData
);

	logic [dataWidth-1:0]    ram [ramWords];
	logic [ramAddrWidth-1:0] ramIdx;
	logic                    ramSel;
	logic [dataWidth-1:0]    readWord;

	assign ramIdx = addr[ramAddrWidth-1:0];
	assign ramSel = (addr[addrWidth-1:ramAddrWidth] == '0);

	// Byte lanes write independently
	always_ff @(posedge CLK) begin
		if (ramSel && !wr0N) begin
			ram[ramIdx][7:0] <= dout[7:0];
		end
		if (ramSel && !wr1N) begin
			ram[ramIdx][15:8] <= dout[15:8];
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			led <= '0;
		end else if (!wr0N && addr == gpioAddr) begin
			led <= dout[7:0]; // Upper lane has no LEDs
		end
	end

	// All I/O registers sit on the low byte lane
	assign wrData    = dout[7:0];
	assign uartWr    = !wr0N && (addr == uartDataAddr);
	assign uartRd    = !rdN && (addr == uartDataAddr);
	assign maskWr    = !wr0N && (addr == intMaskAddr);
	assign pendClrWr = !wr0N && (addr == intPendAddr);

	always_comb begin
		readWord = '0; // Unmapped space reads zero
		if (ramSel) begin
			readWord = ram[ramIdx];
		end else begin
			case (addr)
				gpioAddr: readWord[3:0] = dipSw;
				uartDataAddr: readWord[7:0] = rxData;
				uartStatusAddr: begin
					readWord[txBusyBit]  = txBusy;
					readWord[rxValidBit] = rxValid;
				end
				intMaskAddr: readWord[numInts-1:0] = intMask;
				intPendAddr: readWord[numInts-1:0] = intPending;
				default: readWord = '0;
			endcase
		end
	end

	assign din = rdN ? '0 : readWord;

endmodule

// File: src/intController.sv
module intController import mcuPkg::*; (
	input  logic               CLK,
	input  logic               rstN,
	input  logic [numInts-2:0] intEdge,
	input  logic               rxValid,
	input  logic               maskWr,
	input  logic               pendClrWr,
	input  logic [7:0]         wrData,
	output logic [numInts-1:0] intMask,
	output logic [numInts-1:0] intPending,
	output logic               int0,
	output logic               int1
);

	logic               rxValidLast;
	logic [numInts-1:0] srcEdge;
	logic [numInts-1:0] clrBits;

	// UART receive takes the top source
	assign srcEdge = {rxValid & ~rxValidLast, intEdge};
	assign clrBits = pendClrWr ? wrData : '0;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			rxValidLast <= 1'b0;
		end else begin
			rxValidLast <= rxValid;
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			intMask <= '0;
		end else if (maskWr) begin
			intMask <= wrData;
		end
	end

	// A new edge beats a clear of the same bit
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			intPending <= '0;
		end else begin
			intPending <= (intPending & ~clrBits) | srcEdge;
		end
	end

	// Low half drives INT0, high half INT1
	assign int0 = |(intPending[numInts/2-1:0] & intMask[numInts/2-1:0]);
	assign int1 = |(intPending[numInts-1:numInts/2] & intMask[numInts-1:numInts/2]);

endmodule

// File: src/uart.sv
module uart import mcuPkg::*; (
	input  logic       CLK,
	input  logic       rstN,
	input  logic       rxdSync,
	input  logic       wr,
	input  logic       rd,
	input  logic [7:0] wrData,
	output logic       txd,
	output logic       txBusy,
	output logic [7:0] rxData,
	output logic       rxValid
);

	typedef enum logic [1:0] {
		rxIdle,
		rxStart,
		rxBits,
		rxStop
	} rxStateType;

	logic [9:0]          txShift;
	logic [3:0]          txBitCnt;
	logic [divWidth-1:0] txDiv;

	rxStateType          rxState;
	logic [divWidth-1:0] rxDiv;
	logic [2:0]          rxBitCnt;
	logic [7:0]          rxShift;
	logic                rxTick;

	// Frame is stop, data, start with the start bit driven first
	assign txd = txShift[0];

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			txShift  <= '1;
			txBitCnt <= '0;
			txDiv    <= '0;
			txBusy   <= 1'b0;
		end else if (!txBusy) begin
			if (wr) begin
				txShift  <= {1'b1, wrData, 1'b0};
				txBitCnt <= '0;
				txDiv    <= '0;
				txBusy   <= 1'b1;
			end
		end else if (txDiv == divLast) begin
			txDiv    <= '0;
			txShift  <= {1'b1, txShift[9:1]};
			txBitCnt <= txBitCnt + 4'd1;
			if (txBitCnt == 4'd9) begin
				txBusy <= 1'b0; // Stop bit done
			end
		end else begin
			txDiv <= txDiv + divWidth'(1);
		end
	end

	assign rxTick = (rxDiv == divLast);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			rxState  <= rxIdle;
			rxDiv    <= '0;
			rxBitCnt <= '0;
			rxValid  <= 1'b0;
		end else begin
			if (rd) begin
				rxValid <= 1'b0;
			end
			rxDiv <= rxDiv + divWidth'(1);
			case (rxState)
				rxIdle: begin
					rxDiv <= '0;
					if (!rxdSync) begin
						rxState <= rxStart;
					end
				end
				rxStart: begin
					if (rxDiv == divMid) begin
						rxDiv    <= '0;
						rxBitCnt <= '0;
						rxState  <= rxdSync ? rxIdle : rxBits; // High again means a glitch
					end
				end
				rxBits: begin
					if (rxTick) begin
						rxDiv    <= '0;
						rxBitCnt <= rxBitCnt + 3'd1;
						if (rxBitCnt == 3'd7) begin
							rxState <= rxStop;
						end
					end
				end
				rxStop: begin
					if (rxTick) begin
						rxState <= rxIdle;
						if (rxdSync) begin
							rxValid <= 1'b1; // Wins over a read in the same cycle
						end
					end
				end
				default: rxState <= rxIdle;
			endcase
		end
	end

	// LSB arrives first so bits shift in from the top
	always_ff @(posedge CLK) begin
		if (rxState == rxBits && rxTick) begin
			rxShift <= {rxdSync, rxShift[7:1]};
		end
		if (rxState == rxStop && rxTick && rxdSync) begin
			rxData <= rxShift; // Overrun simply replaces the held byte
		end
	end

endmodule

// File: src/devBoard.sv
module devBoard (
	input  logic       CLK,
	input  logic       arstN,
	input  logic [6:0] intPins,
	input  logic       rxd,
	output logic       rstN,
	output logic [6:0] intEdge,
	output logic       rxdSync
);

	logic [1:0] rstSync;
	logic [6:0] intMeta;
	logic [6:0] intSync;
	logic [6:0] intLast;
	logic       rxdMeta;

	// Asserts at once, releases on the second edge
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			rstSync <= 2'b00;
		end else begin
			rstSync <= {rstSync[0], 1'b1};
		end
	end

	assign rstN = rstSync[1];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			intMeta <= '0;
			intSync <= '0;
			intLast <= '0;
		end else begin
			intMeta <= intPins;
			intSync <= intMeta;
			intLast <= intSync; // Previous synced level for edge detect
		end
	end

	// One cycle pulse per rising edge
	assign intEdge = intSync & ~intLast;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			rxdMeta <= 1'b1; // Serial line idles high
			rxdSync <= 1'b1;
		end else begin
			rxdMeta <= rxd;
			rxdSync <= rxdMeta;
		end
	end

endmodule

// File: src/mcuPkg.sv
package mcuPkg;

	// CPU bus
	localparam int dataWidth = 16;
	localparam int addrWidth = 16;

	// On-chip RAM sits at the bottom of the address space
	localparam int ramWords     = 1024;
	localparam int ramAddrWidth = $clog2(ramWords);

	// I/O registers, word addressed
	localparam logic [addrWidth-1:0] gpioAddr       = 16'hF000;
	localparam logic [addrWidth-1:0] uartDataAddr   = 16'hF001;
	localparam logic [addrWidth-1:0] uartStatusAddr = 16'hF002;
	localparam logic [addrWidth-1:0] intMaskAddr    = 16'hF003;
	localparam logic [addrWidth-1:0] intPendAddr    = 16'hF004;

	// Pins INT0..INT6 plus the UART receive edge in the top bit
	localparam int numInts = 8;

	// Serial bit timing
	localparam int clocksPerBit = 8;
	localparam int divWidth     = $clog2(clocksPerBit);

	// Last count of a bit period, and the count that lands mid-bit
	localparam logic [divWidth-1:0] divLast = divWidth'(clocksPerBit - 1);
	localparam logic [divWidth-1:0] divMid  = divWidth'(clocksPerBit / 2 - 1);

	// UART status word
	localparam int txBusyBit  = 0;
	localparam int rxValidBit = 1;

endpackage
